//--- verilog.f
+incdir+design
design/lc3b_types.sv
design/mem_arbiter.sv
design/instruction_fetch.sv
design/instruction_decode.sv
design/execution_module.sv
design/memory_module.sv
design/writeback_module.sv
design/cpu_datapath.sv
design/cpu_top.sv
verif/cpu_tb.sv

//--- Makefile
TOP = cpu_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

//--- verif/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_config.svh"

module cpu_tb import lc3b_types::*; ();

	localparam int read_timeout = 10;
	localparam int write_timeout = 100;
	localparam int loop_timeout = 200;

	localparam logic [3:0] opc_br = 4'b0000;
	localparam logic [3:0] opc_add = 4'b0001;
	localparam logic [3:0] opc_ldb = 4'b0010;
	localparam logic [3:0] opc_stb = 4'b0011;
	localparam logic [3:0] opc_and = 4'b0101;
	localparam logic [3:0] opc_ldr = 4'b0110;
	localparam logic [3:0] opc_str = 4'b0111;
	localparam logic [3:0] opc_not = 4'b1001;
	localparam logic [3:0] opc_lea = 4'b1110;

	logic clk;
	logic rst;
	lc3b_word mem_rdata;
	lc3b_word mem_addr;
	lc3b_word mem_wdata;
	logic mem_read;
	logic mem_write;
	lc3b_mem_wmask mem_byte_enable;

	lc3b_word mem [256];
	logic [7:0] pc_idx;
	integer seed;
	int write_count = 0;
	int mismatches;
	int failures;
	logic timed_out;

	string exp_name [16];
	lc3b_word exp_addr [16];
	lc3b_word exp_data [16];
	lc3b_mem_wmask exp_be [16];
	int exp_count;

	lc3b_word d0;
	lc3b_word d1;
	lc3b_word d2;
	lc3b_word d3;
	lc3b_word r6;
	lc3b_word loop_addr;
	lc3b_word skip_a;
	lc3b_word skip_b;
	logic [4:0] imm_a;
	logic [4:0] imm_b;

	cpu_top cpu_top_inst (
		.clk(clk),
		.rst(rst),
		.mem_rdata(mem_rdata),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_byte_enable(mem_byte_enable)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ************************************************************************
	// instruction encoding and program
	// ************************************************************************

	function automatic lc3b_word reg_form(input logic [3:0] opc, input logic [2:0] dr,
			input logic [2:0] sr1, input logic [2:0] sr2);
		return {opc, dr, sr1, 3'b000, sr2};
	endfunction

	function automatic lc3b_word imm_form(input logic [3:0] opc, input logic [2:0] dr,
			input logic [2:0] sr1, input logic [4:0] imm5);
		return {opc, dr, sr1, 1'b1, imm5};
	endfunction

	function automatic lc3b_word offset_form(input logic [3:0] opc, input logic [2:0] r,
			input logic [2:0] base, input logic [5:0] off6);
		return {opc, r, base, off6};
	endfunction

	function automatic lc3b_word branch_word(input logic [2:0] nzp, input logic [8:0] off9);
		return {opc_br, nzp, off9};
	endfunction

	function automatic lc3b_word lea_word(input logic [2:0] dr, input logic [8:0] off9);
		return {opc_lea, dr, off9};
	endfunction

	function automatic lc3b_word not_word(input logic [2:0] dr, input logic [2:0] sr);
		return {opc_not, dr, sr, 6'b111111};
	endfunction

	function automatic lc3b_word sext5(input logic [4:0] imm5);
		return {{11{imm5[4]}}, imm5};
	endfunction

	function automatic lc3b_word word_target(input logic [5:0] off6);
		return r6 + {{9{off6[5]}}, off6, 1'b0}; // STR and LDR scale the offset by two.
	endfunction

	function automatic lc3b_word fill_word(input logic [7:0] idx);
		return {idx ^ 8'h5a, ~idx};
	endfunction

	task automatic emit(input lc3b_word w);
		mem[pc_idx] = w;
		pc_idx = pc_idx + 8'd1;
	endtask

	task automatic emit_nops(input int n);
		for (int k = 0; k < n; k++) begin
			emit(16'h0000); // BR with no condition bits never branches.
		end
	endtask

	task automatic expect_store(input string name, input lc3b_word addr, input lc3b_word data,
			input lc3b_mem_wmask be);
		exp_name[exp_count[3:0]] = name;
		exp_addr[exp_count[3:0]] = addr;
		exp_data[exp_count[3:0]] = data;
		exp_be[exp_count[3:0]] = be;
		exp_count++;
	endtask

	task automatic load_program();
		logic [31:0] rnd;
		logic [8:0] lea_off;
		begin
			seed = 32'hc47a;
			exp_count = 0;
			for (int i = 0; i < 256; i++) begin
				mem[i[7:0]] = fill_word(i[7:0]);
			end
			rnd = $random(seed);
			d0 = rnd[15:0];
			rnd = $random(seed);
			d1 = rnd[15:0];
			rnd = $random(seed);
			d2 = rnd[15:0];
			rnd = $random(seed);
			d3 = rnd[15:0] | 16'h8000; // the loaded byte always has its top bit set.
			rnd = $random(seed);
			imm_a = rnd[4:0];
			imm_b = rnd[9:5];
			mem[8'h80] = d0; // operands sit at byte addresses 0x100 to 0x107.
			mem[8'h81] = d1;
			mem[8'h82] = d2;
			mem[8'h83] = d3;

			pc_idx = 8'h00;
			lea_off = 9'd127;
			r6 = {7'b0, pc_idx, 1'b0} + 16'd2 + {{6{lea_off[8]}}, lea_off, 1'b0};
			emit(lea_word(3'd6, lea_off));
			emit_nops(3);
			emit(offset_form(opc_ldr, 3'd1, 3'd6, 6'd0));
			emit(offset_form(opc_ldr, 3'd2, 3'd6, 6'd1));
			emit(offset_form(opc_ldr, 3'd3, 3'd6, 6'd2));
			emit(offset_form(opc_ldb, 3'd4, 3'd6, 6'd7)); // odd byte, high half of d3.
			emit(offset_form(opc_str, 3'd6, 3'd6, 6'd16));
			expect_store("lea_str", word_target(6'd16), r6, 2'b11);
			emit_nops(3);

			emit(reg_form(opc_add, 3'd5, 3'd1, 3'd2));
			emit(reg_form(opc_and, 3'd7, 3'd1, 3'd2));
			emit(imm_form(opc_add, 3'd0, 3'd1, imm_a));
			emit_nops(3);
			emit(offset_form(opc_str, 3'd5, 3'd6, 6'd17));
			emit(offset_form(opc_str, 3'd7, 3'd6, 6'd18));
			emit(offset_form(opc_str, 3'd0, 3'd6, 6'd19));
			expect_store("add_reg", word_target(6'd17), d0 + d1, 2'b11);
			expect_store("and_reg", word_target(6'd18), d0 & d1, 2'b11);
			expect_store("add_imm", word_target(6'd19), d0 + sext5(imm_a), 2'b11);

			emit(imm_form(opc_and, 3'd5, 3'd1, imm_b));
			emit(not_word(3'd7, 3'd2));
			emit_nops(3);
			emit(offset_form(opc_str, 3'd5, 3'd6, 6'd20));
			emit(offset_form(opc_str, 3'd7, 3'd6, 6'd21));
			emit(offset_form(opc_str, 3'd3, 3'd6, 6'd22));
			emit(offset_form(opc_stb, 3'd4, 3'd6, 6'd30));
			emit(offset_form(opc_str, 3'd4, 3'd6, 6'd23));
			expect_store("and_imm", word_target(6'd20), d0 & sext5(imm_b), 2'b11);
			expect_store("not", word_target(6'd21), ~d1, 2'b11);
			expect_store("ldr_str", word_target(6'd22), d2, 2'b11);
			expect_store("ldb_stb", r6 + 16'd30, {8'h00, d3[15:8]}, 2'b01);
			expect_store("ldb_zero_ext", word_target(6'd23), {8'h00, d3[15:8]}, 2'b11);

			emit(imm_form(opc_and, 3'd5, 3'd1, 5'd0)); // flags become Z.
			emit(branch_word(3'b010, 9'd1));
			emit(offset_form(opc_str, 3'd1, 3'd6, 6'd24));
			emit(branch_word(3'b101, 9'd1));
			emit(offset_form(opc_str, 3'd1, 3'd6, 6'd25));
			expect_store("brnp_not_taken", word_target(6'd25), d0, 2'b11);
			emit(imm_form(opc_add, 3'd0, 3'd6, 5'd0)); // flags become P.
			emit(branch_word(3'b001, 9'd1));
			emit(offset_form(opc_str, 3'd2, 3'd6, 6'd26));
			emit(branch_word(3'b100, 9'd1));
			emit(offset_form(opc_str, 3'd2, 3'd6, 6'd27));
			expect_store("brn_not_taken", word_target(6'd27), d1, 2'b11);
			skip_a = word_target(6'd24);
			skip_b = word_target(6'd26);
			loop_addr = {7'b0, pc_idx, 1'b0};
			emit(branch_word(3'b111, 9'h1ff));
		end
	endtask

	// ************************************************************************
	// memory model
	// ************************************************************************

	assign mem_rdata = mem[mem_addr[8:1]];

	initial begin
		load_program();
		forever begin
			@(posedge clk);
			if (mem_write === 1'b1) begin
				if (mem_byte_enable[0]) mem[mem_addr[8:1]][7:0] = mem_wdata[7:0];
				if (mem_byte_enable[1]) mem[mem_addr[8:1]][15:8] = mem_wdata[15:8];
			end
		end
	end

	always @(negedge clk) begin
		if (mem_write === 1'b1) write_count++;
	end

	// ************************************************************************
	// checks
	// ************************************************************************

	task automatic wait_for_first_read();
		int n;
		begin
			n = 0;
			while (mem_read !== 1'b1 && n < read_timeout) begin
				@(negedge clk);
				n++;
			end
			assert (mem_read === 1'b1) else begin
				failures++;
				timed_out = 1'b1;
				$display("timed out waiting for the first instruction read after reset");
			end
		end
	endtask

	task automatic wait_for_write(input int idx);
		int n;
		begin
			n = 0;
			@(negedge clk);
			while (mem_write !== 1'b1 && n < write_timeout) begin
				@(negedge clk);
				n++;
			end
			assert (mem_write === 1'b1) else begin
				failures++;
				timed_out = 1'b1;
				$display("timed out after %0d cycles waiting for bus write %0d", n, idx);
			end
		end
	endtask

	task automatic check_store(input logic [3:0] idx);
		lc3b_word lane_mask;
		begin
			lane_mask = {{8{exp_be[idx][1]}}, {8{exp_be[idx][0]}}}; // only enabled lanes count.
			assert (mem_addr == exp_addr[idx]) else begin
				mismatches++;
				$display("Mismatch %s address: expected %h actual %h", exp_name[idx],
					exp_addr[idx], mem_addr);
			end
			assert (mem_byte_enable == exp_be[idx]) else begin
				mismatches++;
				$display("Mismatch %s enables: expected %b actual %b", exp_name[idx],
					exp_be[idx], mem_byte_enable);
			end
			assert (mem_read === 1'b0) else begin
				mismatches++;
				$display("Mismatch %s read strobe: expected 0 actual %b", exp_name[idx],
					mem_read);
			end
			assert ((mem_wdata & lane_mask) == (exp_data[idx] & lane_mask)) else begin
				mismatches++;
				$display("Mismatch %s data: expected %h actual %h", exp_name[idx],
					exp_data[idx] & lane_mask, mem_wdata & lane_mask);
			end
		end
	endtask

	// the loop branch has resolved once its own address is fetched a second time.
	task automatic wait_for_self_loop();
		int n;
		int hits;
		begin
			n = 0;
			hits = 0;
			while (hits < 2 && n < loop_timeout) begin
				@(negedge clk);
				n++;
				if (mem_read === 1'b1 && mem_write === 1'b0 && mem_addr == loop_addr) hits++;
			end
			assert (hits >= 2) else begin
				failures++;
				timed_out = 1'b1;
				$display("timed out waiting for the final self-loop branch");
			end
		end
	endtask

	initial begin
		rst = 1'b1;
		mismatches = 0;
		failures = 0;
		timed_out = 1'b0;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		wait_for_first_read();
		if (!timed_out) begin
			assert (mem_write === 1'b0) else begin
				mismatches++;
				$display("Mismatch reset mem_write: expected 0 actual %b", mem_write);
			end
			assert (mem_addr == `LC3B_RESET_PC) else begin
				mismatches++;
				$display("Mismatch reset fetch address: expected %h actual %h",
					`LC3B_RESET_PC, mem_addr);
			end
		end
		for (int i = 0; i < exp_count && !timed_out; i++) begin
			wait_for_write(i);
			if (!timed_out) check_store(i[3:0]);
		end
		if (!timed_out) wait_for_self_loop();
		if (!timed_out) begin
			assert (write_count == exp_count) else begin
				mismatches++;
				$display("Mismatch write count: expected %0d actual %0d", exp_count, write_count);
			end
			assert (mem[skip_a[8:1]] == fill_word(skip_a[8:1]) &&
					mem[skip_b[8:1]] == fill_word(skip_b[8:1])) else begin
				failures++;
				$display("a store behind a taken branch changed memory");
			end
		end
		$display("cpu_tb: %0d mismatches, %0d other errors", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule : cpu_tb

`default_nettype wire

//--- design/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top import lc3b_types::*; (
	input logic clk,
	input logic rst,
	input lc3b_word mem_rdata,
	output lc3b_word mem_addr,
	output lc3b_word mem_wdata,
	output logic mem_read,
	output logic mem_write,
	output lc3b_mem_wmask mem_byte_enable
);

	logic fetch_req;
	logic fetch_grant;
	logic data_req;
	logic data_write;
	lc3b_word fetch_addr;
	lc3b_word data_addr;
	lc3b_word data_wdata;
	lc3b_mem_wmask data_byte_enable;

	cpu_datapath cpu_datapath_inst (
		.clk(clk),
		.rst(rst),
		.fetch_grant(fetch_grant),
		.mem_rdata(mem_rdata),
		.fetch_req(fetch_req),
		.fetch_addr(fetch_addr),
		.data_req(data_req),
		.data_write(data_write),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_byte_enable(data_byte_enable)
	);

	mem_arbiter mem_arbiter_inst (
		.fetch_req(fetch_req),
		.data_req(data_req),
		.data_write(data_write),
		.fetch_addr(fetch_addr),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_byte_enable(data_byte_enable),
		.fetch_grant(fetch_grant),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_byte_enable(mem_byte_enable)
	);

endmodule : cpu_top

`default_nettype wire

//--- design/cpu_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_datapath import lc3b_types::*; (
	input logic clk,
	input logic rst,
	input logic fetch_grant,
	input lc3b_word mem_rdata,
	output logic fetch_req,
	output lc3b_word fetch_addr,
	output logic data_req,
	output logic data_write,
	output lc3b_word data_addr,
	output lc3b_word data_wdata,
	output lc3b_mem_wmask data_byte_enable
);

	lc3b_word pc;
	logic branch_taken;
	lc3b_word branch_target;

	logic ifid_valid;
	lc3b_instr ifid_instr;
	lc3b_word ifid_pc_next;

	lc3b_word id_sr1;
	lc3b_word id_sr2;
	lc3b_control id_control;

	logic idex_valid;
	lc3b_instr idex_instr;
	lc3b_word idex_pc_next;
	lc3b_word idex_sr1;
	lc3b_word idex_sr2;
	lc3b_control idex_control;

	lc3b_word ex_alu;
	lc3b_word ex_addr;

	logic exmem_valid;
	lc3b_instr exmem_instr;
	lc3b_word exmem_pc_next;
	lc3b_word exmem_alu;
	lc3b_word exmem_addr;
	lc3b_word exmem_store;
	lc3b_control exmem_control;

	logic mem_valid;
	lc3b_word mem_load_data;

	logic memwb_valid;
	lc3b_instr memwb_instr;
	lc3b_word memwb_pc_next;
	lc3b_word memwb_alu;
	lc3b_word memwb_addr;
	lc3b_word memwb_load;
	lc3b_control memwb_control;

	logic wb_load;
	lc3b_reg wb_dest;
	lc3b_word wb_data;

	assign fetch_addr = pc;
	assign mem_valid = exmem_valid & ~branch_taken; // a taken branch also kills the memory access.

	// ************************************************************************
	// stage registers
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			ifid_valid <= 1'b0;
			idex_valid <= 1'b0;
			exmem_valid <= 1'b0;
			memwb_valid <= 1'b0;
		end else begin
			ifid_valid <= fetch_grant & ~branch_taken; // no grant loads a bubble.
			idex_valid <= ifid_valid & ~branch_taken;
			exmem_valid <= idex_valid & ~branch_taken;
			memwb_valid <= mem_valid;
		end
	end

	always_ff @(posedge clk) begin
		ifid_instr <= mem_rdata;
		ifid_pc_next <= pc + 16'd2;

		idex_instr <= ifid_instr;
		idex_pc_next <= ifid_pc_next;
		idex_sr1 <= id_sr1;
		idex_sr2 <= id_sr2;
		idex_control <= id_control;

		exmem_instr <= idex_instr;
		exmem_pc_next <= idex_pc_next;
		exmem_alu <= ex_alu;
		exmem_addr <= ex_addr;
		exmem_store <= idex_sr2;
		exmem_control <= idex_control;

		memwb_instr <= exmem_instr;
		memwb_pc_next <= exmem_pc_next;
		memwb_alu <= exmem_alu;
		memwb_addr <= exmem_addr;
		memwb_load <= mem_load_data;
		memwb_control <= exmem_control;
	end

	// ************************************************************************
	// stages
	// ************************************************************************

	instruction_fetch instruction_fetch_inst (
		.clk(clk),
		.rst(rst),
		.fetch_grant(fetch_grant),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.pc(pc),
		.fetch_req(fetch_req)
	);

	instruction_decode instruction_decode_inst (
		.clk(clk),
		.rst(rst),
		.instr(ifid_instr),
		.wb_load(wb_load),
		.wb_dest(wb_dest),
		.wb_data(wb_data),
		.sr1_data(id_sr1),
		.sr2_data(id_sr2),
		.control(id_control)
	);

	execution_module execution_module_inst (
		.instr(idex_instr),
		.pc_next(idex_pc_next),
		.sr1_data(idex_sr1),
		.sr2_data(idex_sr2),
		.control(idex_control),
		.alu_out(ex_alu),
		.addr_out(ex_addr)
	);

	memory_module memory_module_inst (
		.valid(mem_valid),
		.control(exmem_control),
		.addr(exmem_addr),
		.store_data(exmem_store),
		.mem_rdata(mem_rdata),
		.data_req(data_req),
		.data_write(data_write),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.load_data(mem_load_data),
		.data_byte_enable(data_byte_enable)
	);

	writeback_module writeback_module_inst (
		.clk(clk),
		.rst(rst),
		.valid(memwb_valid),
		.instr(memwb_instr),
		.control(memwb_control),
		.pc_next(memwb_pc_next),
		.alu_out(memwb_alu),
		.addr_out(memwb_addr),
		.load_data(memwb_load),
		.reg_load(wb_load),
		.branch_taken(branch_taken),
		.reg_dest(wb_dest),
		.reg_data(wb_data),
		.branch_target(branch_target)
	);

endmodule : cpu_datapath

`default_nettype wire

//--- design/writeback_module.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_module import lc3b_types::*; (
	input logic clk,
	input logic rst,
	input logic valid,
	input lc3b_instr instr,
	input lc3b_control control,
	input lc3b_word pc_next,
	input lc3b_word alu_out,
	input lc3b_word addr_out,
	input lc3b_word load_data,
	output logic reg_load,
	output logic branch_taken,
	output lc3b_reg reg_dest,
	output lc3b_word reg_data,
	output lc3b_word branch_target
);

	logic [2:0] cc; // n, z, p.

	always_comb begin
		case (control.wbsel)
			wb_mem_word, wb_mem_byte: reg_data = load_data;
			wb_addr: reg_data = addr_out;
			default: reg_data = alu_out;
		endcase
	end

	assign reg_load = valid & control.reg_load;
	assign reg_dest = instr.r.dr;

	always_ff @(posedge clk) begin
		if (rst) begin
			cc <= 3'b010;
		end else if (valid && control.set_cc) begin
			cc <= {reg_data[15], reg_data == '0, !reg_data[15] && reg_data != '0};
		end
	end

	assign branch_target = pc_next + {{6{instr.b.offset9[8]}}, instr.b.offset9, 1'b0};
	assign branch_taken = valid & control.is_branch & |(instr.b.nzp & cc);

endmodule : writeback_module

`default_nettype wire

//--- design/memory_module.sv
`timescale 1ns/1ps
`default_nettype none

module memory_module import lc3b_types::*; (
	input logic valid,
	input lc3b_control control,
	input lc3b_word addr,
	input lc3b_word store_data,
	input lc3b_word mem_rdata,
	output logic data_req,
	output logic data_write,
	output lc3b_word data_addr,
	output lc3b_word data_wdata,
	output lc3b_word load_data,
	output lc3b_mem_wmask data_byte_enable
);

	assign data_req = valid & (control.mem_read | control.mem_write);
	assign data_write = valid & control.mem_write;
	assign data_addr = addr;

	// a byte store is copied onto both lanes and the enable picks one.
	assign data_wdata = control.byte_access ? {store_data[7:0], store_data[7:0]} : store_data;
	assign data_byte_enable = !control.byte_access ? 2'b11 : addr[0] ? 2'b10 : 2'b01;

	assign load_data = !control.byte_access ? mem_rdata :
		addr[0] ? {8'h00, mem_rdata[15:8]} : {8'h00, mem_rdata[7:0]};

endmodule : memory_module

`default_nettype wire

//--- design/execution_module.sv
`timescale 1ns/1ps
`default_nettype none

module execution_module import lc3b_types::*; (
	input lc3b_instr instr,
	input lc3b_word pc_next,
	input lc3b_word sr1_data,
	input lc3b_word sr2_data,
	input lc3b_control control,
	output lc3b_word alu_out,
	output lc3b_word addr_out
);

	lc3b_word imm5_sext;
	lc3b_word offset6_sext;
	lc3b_word offset9_sext;
	lc3b_word operand_b;

	assign imm5_sext = {{11{instr.r.sr2_imm5[4]}}, instr.r.sr2_imm5};
	assign offset6_sext = {{10{instr.o.offset6[5]}}, instr.o.offset6};
	assign offset9_sext = {{7{instr.b.offset9[8]}}, instr.b.offset9};
	assign operand_b = control.imm_sel ? imm5_sext : sr2_data;

	always_comb begin
		case (control.aluop)
			alu_add: alu_out = sr1_data + operand_b;
			alu_and: alu_out = sr1_data & operand_b;
			alu_not: alu_out = ~sr1_data;
			default: alu_out = sr1_data;
		endcase
	end

	// byte accesses use the offset unscaled.
	assign addr_out = control.addr_sel ? pc_next + (offset9_sext << 1) :
		control.byte_access ? sr1_data + offset6_sext : sr1_data + (offset6_sext << 1);

endmodule : execution_module

`default_nettype wire

//--- design/instruction_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_config.svh"

module instruction_decode import lc3b_types::*; (
	input logic clk,
	input logic rst,
	input lc3b_instr instr,
	input logic wb_load,
	input lc3b_reg wb_dest,
	input lc3b_word wb_data,
	output lc3b_word sr1_data,
	output lc3b_word sr2_data,
	output lc3b_control control
);

	lc3b_word regs [`LC3B_NUM_REGS];
	lc3b_reg sr1_idx;
	lc3b_reg sr2_idx;

	// ************************************************************************
	// control word
	// ************************************************************************

	always_comb begin
		control.aluop = alu_pass;
		control.imm_sel = 1'b0;
		control.addr_sel = 1'b0;
		control.mem_read = 1'b0;
		control.mem_write = 1'b0;
		control.byte_access = 1'b0;
		control.reg_load = 1'b0;
		control.wbsel = wb_alu;
		control.set_cc = 1'b0;
		control.is_branch = 1'b0;
		case (instr.r.opcode)
			op_add, op_and: begin
				control.aluop = (instr.r.opcode == op_add) ? alu_add : alu_and;
				control.imm_sel = instr.r.imm_flag;
				control.reg_load = 1'b1;
				control.set_cc = 1'b1;
			end
			op_not: begin
				control.aluop = alu_not;
				control.reg_load = 1'b1;
				control.set_cc = 1'b1;
			end
			op_lea: begin
				control.addr_sel = 1'b1;
				control.reg_load = 1'b1;
				control.wbsel = wb_addr; // LC-3b LEA leaves the flags alone.
			end
			op_br: begin
				control.is_branch = 1'b1;
			end
			op_ldr, op_ldb: begin
				control.mem_read = 1'b1;
				control.byte_access = (instr.o.opcode == op_ldb);
				control.reg_load = 1'b1;
				control.wbsel = (instr.o.opcode == op_ldb) ? wb_mem_byte : wb_mem_word;
				control.set_cc = 1'b1;
			end
			op_str, op_stb: begin
				control.mem_write = 1'b1;
				control.byte_access = (instr.o.opcode == op_stb);
			end
			default: begin
			end
		endcase
	end

	// ************************************************************************
	// register file
	// ************************************************************************

	assign sr1_idx = instr.r.sr1;
	assign sr2_idx = control.mem_write ? instr.o.dr_sr : instr.r.sr2_imm5[2:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_load) begin
			regs[wb_dest] <= wb_data;
		end
	end

	// the write in flight is visible to this cycle's read.
	assign sr1_data = (wb_load && wb_dest == sr1_idx) ? wb_data : regs[sr1_idx];
	assign sr2_data = (wb_load && wb_dest == sr2_idx) ? wb_data : regs[sr2_idx];

endmodule : instruction_decode

`default_nettype wire

//--- design/instruction_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_config.svh"

module instruction_fetch import lc3b_types::*; (
	input logic clk,
	input logic rst,
	input logic fetch_grant,
	input logic branch_taken,
	input lc3b_word branch_target,
	output lc3b_word pc,
	output logic fetch_req
);

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `LC3B_RESET_PC;
			fetch_req <= 1'b0;
		end else begin
			fetch_req <= 1'b1; // fetch asks every cycle once out of reset.
			if (branch_taken) begin
				pc <= branch_target; // redirect wins over a granted fetch.
			end else if (fetch_grant) begin
				pc <= pc + 16'd2;
			end
		end
	end

endmodule : instruction_fetch

`default_nettype wire

//--- design/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import lc3b_types::*; (
	input logic fetch_req,
	input logic data_req,
	input logic data_write,
	input lc3b_word fetch_addr,
	input lc3b_word data_addr,
	input lc3b_word data_wdata,
	input lc3b_mem_wmask data_byte_enable,
	output logic fetch_grant,
	output logic mem_read,
	output logic mem_write,
	output lc3b_word mem_addr,
	output lc3b_word mem_wdata,
	output lc3b_mem_wmask mem_byte_enable
);

	assign fetch_grant = fetch_req & ~data_req; // the data side always wins.
	assign mem_read = data_req ? ~data_write : fetch_req;
	assign mem_write = data_req & data_write;
	assign mem_addr = data_req ? data_addr : fetch_addr;
	assign mem_wdata = data_wdata;
	assign mem_byte_enable = data_req ? data_byte_enable : 2'b11; // instruction reads are full words.

endmodule : mem_arbiter

`default_nettype wire

//--- design/lc3b_types.sv
`default_nettype none

`include "lc3b_config.svh"

package lc3b_types;

	typedef logic [`LC3B_WIDTH-1:0] lc3b_word;
	typedef logic [1:0] lc3b_mem_wmask;
	typedef logic [$clog2(`LC3B_NUM_REGS)-1:0] lc3b_reg;

	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_ldb = 4'b0010,
		op_stb = 4'b0011,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001,
		op_lea = 4'b1110
	} lc3b_opcode;

	// ADD, AND and NOT. sr2 sits in the low three bits of sr2_imm5.
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dr;
		lc3b_reg sr1;
		logic imm_flag;
		logic [4:0] sr2_imm5;
	} lc3b_instr_reg;

	// LDR, STR, LDB and STB. dr_sr is the destination on loads and the source on stores.
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dr_sr;
		lc3b_reg base;
		logic [5:0] offset6;
	} lc3b_instr_off;

	// BR and LEA.
	typedef struct packed {
		lc3b_opcode opcode;
		logic [2:0] nzp;
		logic [8:0] offset9;
	} lc3b_instr_br;

	typedef union packed {
		lc3b_instr_reg r;
		lc3b_instr_off o;
		lc3b_instr_br b;
	} lc3b_instr;

	typedef enum logic [1:0] {alu_add, alu_and, alu_not, alu_pass} lc3b_aluop;

	typedef enum logic [1:0] {wb_alu, wb_mem_word, wb_mem_byte, wb_addr} lc3b_wbsel;

	typedef struct packed {
		lc3b_aluop aluop;
		logic imm_sel;
		logic addr_sel;      // high selects PC plus offset9.
		logic mem_read;
		logic mem_write;
		logic byte_access;
		logic reg_load;
		lc3b_wbsel wbsel;
		logic set_cc;
		logic is_branch;
	} lc3b_control;

endpackage : lc3b_types

`default_nettype wire

//--- design/lc3b_config.svh
`ifndef LC3B_CONFIG_SVH
`define LC3B_CONFIG_SVH

// datapath word width in bits.
`define LC3B_WIDTH 16

// first fetch address after reset.
`define LC3B_RESET_PC 16'h0000

// number of general purpose registers.
`define LC3B_NUM_REGS 8

`endif
